// ==== test/acq_vectors.txt ====
# all fields hex: cfg addr data, reg addr expect, ttc type num word, drop type num
# dones mask, pulse level trig, state code, idle cycles, pop, done, noevt, test id
test 1
reg 2 00000040
reg 0 0000001f
reg 1 00000000
cfg 0 00000015
cfg 1 00000003
reg 0 00000015
reg 1 00000003
cfg 2 ffffffff
reg 2 00000040
test 2
ttc 5 123456 05123456
state 1
dones 15
state 3
pop
reg 2 00000033
done
reg 2 00000040
test 3
ttc 2 abcdef 02abcdef
dones 0a
reg 2 00000041
dones 01
dones 04
reg 2 00000041
dones 10
state 3
pop
done
test 4
pulse 1 15
pulse 0 00
cfg 1 00000001
pulse 1 00
cfg 1 00000002
pulse 1 00
cfg 1 00000003
ttc 1 000001 01000001
pulse 1 00
dones 15
state 3
pulse 1 00
pop
done
test 5
ttc 0 000010 00000010
dones 1f
state 3
done
ttc 7 000020 07000020
dones 15
state 3
done
ttc 3 000030 03000030
dones 15
state 3
done
ttc 4 ffffff 04ffffff
dones 15
state 3
done
reg 2 00000000
ttc 6 000050 06000050
dones 15
state 2
reg 2 00000002
drop 1 000061
drop 1 000062
drop 1 000063
reg 2 00000302
pop
state 3
done
pop
pop
pop
pop
idle 4
reg 2 00000340
test 6
cfg 1 00000002
drop 5 000070
reg 2 00000340
noevt
reg 2 00000340

// ==== sim.f ====
common/acq_pkg.sv
hdl/trig_config_regs.sv
acq_ctrl/channel_acq_controller.sv
acq_ctrl/acq_event_fifo.sv
hdl/acq_trigger_top.sv
test/acq_chk.sv
test/acq_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module acq_tb -o Vacq_tb
	./obj_dir/Vacq_tb | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/acq_tb.sv ====
/* vector driven testbench for acq_trigger_top; reads test/acq_vectors.txt from the
   project root, every wait gives up after 200 cycles */
`timescale 1ns/1ps

module acq_tb;

  localparam int NUM_CHAN   = 5;
  localparam int FIFO_DEPTH = 4;
  localparam int EVT_W      = acq_pkg::EVT_W;
  localparam int TIMEOUT    = 200;

  logic clk = 1'b0, reset, cfg_we, ttc_trigger, pulse_trigger, readout_done, evt_pop;
  acq_pkg::cfg_reg_t cfg_addr;
  logic [31:0] cfg_wdata, cfg_rdata;
  logic [acq_pkg::TRIG_TYPE_W-1:0] ttc_trig_type;
  logic [acq_pkg::TRIG_NUM_W-1:0]  ttc_trig_num;
  logic [NUM_CHAN-1:0]   acq_dones, acq_trig;
  logic [2*NUM_CHAN-1:0] acq_enable;
  logic ttc_acq_ready, evt_valid;
  logic [EVT_W-1:0] evt_data;

  integer fd, n, errors = 0, err_mark = 0, cur_test = 0, tests_ok = 0, tests_bad = 0;
  logic [127:0] op;
  logic [EVT_W-1:0] exp_q[$]; // expected words in fifo order
  logic [1:0] mode_q = 2'b00; // last mode written, bit 0 async, bit 1 accept
  logic busy = 1'b0;          // accepted trigger not yet read out

  always #20 clk = ~clk; // 40 ns period

  acq_trigger_top #(.NUM_CHAN(NUM_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) u_acq_trigger_top (.*);

  task automatic tick();
    @(posedge clk);
    #2; // drive just after the edge
  endtask

  task automatic check_word(input logic [EVT_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input acq_pkg::acq_state_t got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_mask(input logic [NUM_CHAN-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_enable(input logic [2*NUM_CHAN-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input logic [31:0] got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic wait_valid();
    int cnt;
    cnt = 0;
    while (!evt_valid && cnt < TIMEOUT) begin
      tick();
      cnt++;
    end
    if (!evt_valid) begin
      $display("timed out at %0t waiting for an event word in the fifo", $time);
      errors++;
    end
  endtask

  task automatic wait_state(input acq_pkg::acq_state_t exp);
    int cnt;
    cnt = 0;
    while (u_acq_trigger_top.u_ctrl.state != exp && cnt < TIMEOUT) begin
      tick();
      cnt++;
    end
    if (u_acq_trigger_top.u_ctrl.state != exp) begin
      $display("timed out at %0t waiting for fsm state %s", $time, exp.name());
      errors++;
    end
  endtask

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    while (!ttc_acq_ready && cnt < TIMEOUT) begin
      tick();
      cnt++;
    end
    if (!ttc_acq_ready) begin
      $display("timed out at %0t waiting for ttc_acq_ready after readout", $time);
      errors++;
    end
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      $display("test %0d ok", cur_test);
      tests_ok++;
    end else begin
      $display("test %0d had %0d errors", cur_test, errors - err_mark);
      tests_bad++;
    end
  endtask

  // one vector record, fields follow the keyword
  task automatic run_op(input logic [127:0] kw);
    logic [31:0] a, b, c;
    logic [8*128-1:0] line;
    logic [2*NUM_CHAN-1:0] exp_en;
    int k;
    if (kw == "#") begin
      k = $fgets(line, fd); // comment line
    end else if (kw == "test") begin
      k = $fscanf(fd, "%h", a);
      if (cur_test != 0) end_test();
      cur_test = a;
      err_mark = errors;
    end else if (kw == "cfg") begin
      k = $fscanf(fd, "%h %h", a, b);
      cfg_addr  = acq_pkg::cfg_reg_t'(a[1:0]);
      cfg_wdata = b;
      cfg_we    = 1'b1;
      if (cfg_addr == acq_pkg::CFG_MODE) begin
        mode_q = b[1:0];
      end
      tick();
      cfg_we    = 1'b0;
    end else if (kw == "reg") begin
      k = $fscanf(fd, "%h %h", a, b);
      cfg_addr = acq_pkg::cfg_reg_t'(a[1:0]);
      #1;
      check_reg(cfg_rdata, b, "register readback");
    end else if (kw == "ttc" || kw == "drop") begin
      k = $fscanf(fd, "%h %h", a, b);
      if (kw == "ttc") begin
        k = $fscanf(fd, "%h", c);
        exp_q.push_back(c); // dropped triggers queue nothing
        busy = 1'b1;
      end
      ttc_trig_type = a[acq_pkg::TRIG_TYPE_W-1:0];
      ttc_trig_num  = b[acq_pkg::TRIG_NUM_W-1:0];
      ttc_trigger   = 1'b1;
      tick();
      ttc_trigger   = 1'b0;
    end else if (kw == "dones") begin
      k = $fscanf(fd, "%h", a);
      acq_dones = a[NUM_CHAN-1:0];
      tick();
      acq_dones = '0;
    end else if (kw == "pulse") begin
      k = $fscanf(fd, "%h %h", a, b);
      exp_en = '0;
      if (mode_q == 2'b11 && !busy) begin
        exp_en = '1; // path open in idle with both mode bits
      end
      pulse_trigger = a[0];
      #10; // passthrough is combinational
      check_mask(acq_trig, b[NUM_CHAN-1:0], "acq_trig during pulse");
      check_enable(acq_enable, exp_en, "acq_enable during pulse");
      tick();
      pulse_trigger = 1'b0;
    end else if (kw == "state") begin
      k = $fscanf(fd, "%h", a);
      wait_state(acq_pkg::acq_state_t'(a[1:0]));
    end else if (kw == "pop") begin
      wait_valid();
      if (exp_q.size() == 0) begin
        $display("an event word was popped but none was expected");
        errors++;
      end else begin
        check_word(evt_data, exp_q.pop_front(), "event word");
      end
      evt_pop = 1'b1;
      tick();
      evt_pop = 1'b0;
    end else if (kw == "done") begin
      check_flag(ttc_acq_ready, 1'b0, "ready before readout_done");
      readout_done = 1'b1;
      tick();
      readout_done = 1'b0;
      busy = 1'b0;
      wait_ready();
      check_state(u_acq_trigger_top.u_ctrl.state, acq_pkg::ACQ_IDLE, "state after readout");
    end else if (kw == "idle") begin
      k = $fscanf(fd, "%h", a);
      repeat (a) tick();
    end else if (kw == "noevt") begin
      for (int i = 0; i < TIMEOUT; i++) begin
        if (evt_valid) begin
          $display("an event word appeared at %0t although none was expected", $time);
          errors++;
          break;
        end
        tick();
      end
      check_state(u_acq_trigger_top.u_ctrl.state, acq_pkg::ACQ_IDLE, "state with no event");
    end else begin
      $display("unknown vector keyword %0s", kw);
      errors++;
    end
  endtask

  initial begin
    reset = 1'b1;
    cfg_we = 1'b0;
    cfg_addr = acq_pkg::CFG_CHAN_EN;
    cfg_wdata = '0;
    ttc_trigger = 1'b0;
    ttc_trig_type = '0;
    ttc_trig_num = '0;
    pulse_trigger = 1'b0;
    acq_dones = '0;
    readout_done = 1'b0;
    evt_pop = 1'b0;
    repeat (5) @(posedge clk);
    #2 reset = 1'b0;
    fd = $fopen("test/acq_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file test/acq_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", op);
        if (n != 1) break;
        run_op(op);
      end
      $fclose(fd);
      if (cur_test != 0) end_test();
    end
    $display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== test/acq_chk.sv ====
/* protocol assertions for the acquisition controller, bound in from the testbench.
   checked only outside reset */
`timescale 1ns/1ps

module acq_chk #(
  parameter int NUM_CHAN   = 5,
  parameter int FIFO_DEPTH = 4
) (
  input logic                            clk,
  input logic                            reset,
  input logic                            evt_wr,
  input logic                            ttc_acq_ready,
  input acq_pkg::acq_state_t             state,
  input logic [$clog2(FIFO_DEPTH+1)-1:0] credits,
  input logic [NUM_CHAN-1:0]             acq_trig
);

  // a write must be covered by a credit
  write_needs_credit: assert property (@(posedge clk) disable iff (reset)
    evt_wr |-> (credits != '0)) else $error("event write with zero credits");

  // credit count bounded by fifo size
  credits_bounded: assert property (@(posedge clk) disable iff (reset)
    credits <= FIFO_DEPTH) else $error("credit count above fifo depth");

  ready_is_idle: assert property (@(posedge clk) disable iff (reset)
    ttc_acq_ready == (state == acq_pkg::ACQ_IDLE)) else $error("ready does not track idle");

  // pulse passthrough only when idle
  no_trig_busy: assert property (@(posedge clk) disable iff (reset)
    (state != acq_pkg::ACQ_IDLE) |-> (acq_trig == '0)) else $error("acq_trig while busy");

endmodule

bind channel_acq_controller acq_chk #(.NUM_CHAN(NUM_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) u_chk (
  .clk(clk), .reset(reset), .evt_wr(evt_wr), .ttc_acq_ready(ttc_acq_ready),
  .state(state), .credits(credits), .acq_trig(acq_trig)
);

// ==== hdl/acq_trigger_top.sv ====
/* async trigger subsystem top; fifo read side, readout done and register port at the pins.
   synchronous mode is not supported */
`timescale 1ns/1ps

module acq_trigger_top #(
  parameter int NUM_CHAN   = 5,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            cfg_we,
  input  acq_pkg::cfg_reg_t               cfg_addr,
  input  logic [31:0]                     cfg_wdata,
  output logic [31:0]                     cfg_rdata,
  input  logic                            ttc_trigger,
  input  logic [acq_pkg::TRIG_TYPE_W-1:0] ttc_trig_type,
  input  logic [acq_pkg::TRIG_NUM_W-1:0]  ttc_trig_num,
  output logic                            ttc_acq_ready,
  input  logic                            pulse_trigger,
  input  logic [NUM_CHAN-1:0]             acq_dones,
  output logic [2*NUM_CHAN-1:0]           acq_enable,
  output logic [NUM_CHAN-1:0]             acq_trig,
  input  logic                            readout_done,
  input  logic                            evt_pop,
  output logic                            evt_valid,
  output logic [acq_pkg::EVT_W-1:0]       evt_data
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  logic [NUM_CHAN-1:0]       chan_en;
  logic                      async_mode, accept_pulse_triggers;
  acq_pkg::acq_state_t       state;
  logic [CRED_W-1:0]         credits;
  logic                      evt_wr, credit_ret;
  logic [acq_pkg::EVT_W-1:0] evt_data_in;

  trig_config_regs #(.NUM_CHAN(NUM_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) u_regs (
    .clk, .reset, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata,
    .state, .credits, .ttc_trigger, .ttc_acq_ready,
    .chan_en, .async_mode, .accept_pulse_triggers
  );

  channel_acq_controller #(.NUM_CHAN(NUM_CHAN), .FIFO_DEPTH(FIFO_DEPTH)) u_ctrl (
    .clk, .reset, .chan_en, .async_mode, .accept_pulse_triggers, .readout_done,
    .ttc_trigger, .ttc_trig_type, .ttc_trig_num, .ttc_acq_ready, .pulse_trigger,
    .acq_dones, .acq_enable, .acq_trig, .credit_ret, .evt_wr, .evt_data_in,
    .state, .credits
  );

  acq_event_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .reset, .evt_wr, .evt_data_in, .evt_pop, .evt_valid, .evt_data, .credit_ret
  );

endmodule

// ==== acq_ctrl/acq_event_fifo.sv ====
/* circular event fifo with registered head; relies on the writer honouring credits,
   a write into a full fifo is not blocked here. depth of 2 or more */
`timescale 1ns/1ps

module acq_event_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      evt_wr,
  input  logic [acq_pkg::EVT_W-1:0] evt_data_in,
  input  logic                      evt_pop,
  output logic                      evt_valid,
  output logic [acq_pkg::EVT_W-1:0] evt_data,   // head word
  output logic                      credit_ret  // one per accepted pop
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [acq_pkg::EVT_W-1:0] mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr, rd_ptr, rd_nxt;
  logic [CNT_W-1:0] count, count_nxt;
  logic             pop_ok;
  logic [acq_pkg::EVT_W-1:0] head_nxt;

  // wrap at depth, not at a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop_ok    = evt_pop && evt_valid; // pop on empty ignored
  assign rd_nxt    = pop_ok ? ptr_inc(rd_ptr) : rd_ptr;
  assign count_nxt = count + CNT_W'(evt_wr) - CNT_W'(pop_ok);

  // word being written now bypasses into the head when it lands at rd_nxt
  assign head_nxt = (evt_wr && (wr_ptr == rd_nxt)) ? evt_data_in : mem[rd_nxt];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      evt_valid  <= 1'b0;
      credit_ret <= 1'b0;
    end else begin
      if (evt_wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr     <= rd_nxt;
      count      <= count_nxt;
      evt_valid  <= (count_nxt != '0);
      credit_ret <= pop_ok; // slot freed, hand credit back
    end
  end

  // storage and head register
  always_ff @(posedge clk) begin
    if (evt_wr) begin
      mem[wr_ptr] <= evt_data_in;
    end
    evt_data <= head_nxt;
  end

endmodule

// ==== acq_ctrl/channel_acq_controller.sv ====
/* async acquisition fsm; one event word per ttc trigger, written only against a credit.
   the pulse passthrough (acq_enable, acq_trig) is combinational, all else is registered */
`timescale 1ns/1ps

module channel_acq_controller #(
  parameter int NUM_CHAN   = 5,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              reset,
  // steering from the register block
  input  logic [NUM_CHAN-1:0]               chan_en,
  input  logic                              async_mode,
  input  logic                              accept_pulse_triggers,
  // command manager
  input  logic                              readout_done,
  // ttc trigger receiver
  input  logic                              ttc_trigger,
  input  logic [acq_pkg::TRIG_TYPE_W-1:0]   ttc_trig_type,
  input  logic [acq_pkg::TRIG_NUM_W-1:0]    ttc_trig_num,
  output logic                              ttc_acq_ready,
  // front panel trigger
  input  logic                              pulse_trigger,
  // channel fpgas
  input  logic [NUM_CHAN-1:0]               acq_dones,
  output logic [2*NUM_CHAN-1:0]             acq_enable,
  output logic [NUM_CHAN-1:0]               acq_trig,
  // event fifo, credit based
  input  logic                              credit_ret,
  output logic                              evt_wr,
  output logic [acq_pkg::EVT_W-1:0]         evt_data_in,
  // status
  output acq_pkg::acq_state_t               state,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]   credits
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  acq_pkg::acq_state_t state_nxt;

  logic [acq_pkg::TRIG_TYPE_W-1:0] trig_type_q, trig_type_nxt; // latched type
  logic [acq_pkg::TRIG_NUM_W-1:0]  trig_num_q, trig_num_nxt;   // latched number
  logic [NUM_CHAN-1:0]             dones_q, dones_nxt;         // dones seen so far

  logic has_credit;
  logic pulse_open; // idle passthrough condition

  assign has_credit = (credits != '0);
  assign pulse_open = async_mode && accept_pulse_triggers && !ttc_trigger;

  // next state and latch logic
  always_comb begin
    state_nxt     = state;
    trig_type_nxt = trig_type_q;
    trig_num_nxt  = trig_num_q;
    dones_nxt     = dones_q;
    acq_enable    = '0;
    acq_trig      = '0;

    case (state)
      acq_pkg::ACQ_IDLE: begin
        if (ttc_trigger && async_mode) begin
          trig_type_nxt = ttc_trig_type;
          trig_num_nxt  = ttc_trig_num;
          dones_nxt     = '0; // fresh collection
          state_nxt     = acq_pkg::ACQ_WAIT_DONES;
        end else if (pulse_open) begin
          acq_enable = '1;
          acq_trig   = pulse_trigger ? chan_en : '0; // enabled channels only
        end
      end
      acq_pkg::ACQ_WAIT_DONES: begin
        dones_nxt = dones_q | (acq_dones & chan_en); // disabled channels ignored
        if (dones_q == chan_en) begin
          state_nxt = acq_pkg::ACQ_STORE_INFO;
        end
      end
      acq_pkg::ACQ_STORE_INFO: begin
        if (has_credit) begin
          state_nxt = acq_pkg::ACQ_READOUT;
        end
        // otherwise hold, fifo is full downstream
      end
      acq_pkg::ACQ_READOUT: begin
        if (readout_done) begin
          state_nxt = acq_pkg::ACQ_IDLE;
        end
      end
      default: state_nxt = acq_pkg::ACQ_IDLE;
    endcase
  end

  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= acq_pkg::ACQ_IDLE;
      ttc_acq_ready <= 1'b1;
      dones_q       <= '0;
      evt_wr        <= 1'b0;
    end else begin
      state         <= state_nxt;
      ttc_acq_ready <= (state_nxt == acq_pkg::ACQ_IDLE); // ready tracks idle
      dones_q       <= dones_nxt;
      evt_wr        <= (state == acq_pkg::ACQ_STORE_INFO) && has_credit; // one cycle
    end
  end

  // credit counter, a write is charged on the edge ending its evt_wr cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CRED_W'(FIFO_DEPTH); // fifo starts empty
    end else begin
      credits <= credits + CRED_W'(credit_ret) - CRED_W'(evt_wr);
    end
  end

  // trigger info and event word
  always_ff @(posedge clk) begin
    trig_type_q <= trig_type_nxt;
    trig_num_q  <= trig_num_nxt;
    if ((state == acq_pkg::ACQ_STORE_INFO) && has_credit) begin
      evt_data_in <= acq_pkg::pack_evt(trig_type_q, trig_num_q);
    end
  end

endmodule

// ==== hdl/trig_config_regs.sv ====
/* config and status registers; writes land on the rising edge, reads are combinational.
   the credit count must fit the 4-bit status field, so FIFO_DEPTH stays below 16 */
`timescale 1ns/1ps

module trig_config_regs #(
  parameter int NUM_CHAN   = 5,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cfg_we,
  input  acq_pkg::cfg_reg_t           cfg_addr,
  input  logic [31:0]                 cfg_wdata,
  output logic [31:0]                 cfg_rdata,
  input  acq_pkg::acq_state_t         state,       // from the controller
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] credits,
  input  logic                        ttc_trigger,
  input  logic                        ttc_acq_ready,
  output logic [NUM_CHAN-1:0]         chan_en,
  output logic                        async_mode,
  output logic                        accept_pulse_triggers
);

  localparam int CRED_FLD_W = acq_pkg::STAT_CRED_W;
  localparam int MISS_W     = acq_pkg::STAT_MISS_W;

  logic [MISS_W-1:0] miss_cnt;    // ttc triggers dropped while busy
  logic [31:0]       status_word;

  // enable mask and mode bits
  always_ff @(posedge clk) begin
    if (reset) begin
      chan_en               <= '1; // all channels on
      async_mode            <= 1'b0;
      accept_pulse_triggers <= 1'b0;
    end else if (cfg_we) begin
      if (cfg_addr == acq_pkg::CFG_CHAN_EN) begin
        chan_en <= cfg_wdata[NUM_CHAN-1:0];
      end
      if (cfg_addr == acq_pkg::CFG_MODE) begin
        async_mode            <= cfg_wdata[acq_pkg::MODE_ASYNC_BIT];
        accept_pulse_triggers <= cfg_wdata[acq_pkg::MODE_ACCEPT_BIT];
      end
      // status address is read only, write dropped
    end
  end

  // saturating missed trigger count
  always_ff @(posedge clk) begin
    if (reset) begin
      miss_cnt <= '0;
    end else if (ttc_trigger && !ttc_acq_ready && (miss_cnt != '1)) begin
      miss_cnt <= miss_cnt + 1'b1;
    end
  end

  always_comb begin
    status_word = '0;
    status_word[acq_pkg::STAT_STATE_LSB +: 2]         = state;
    status_word[acq_pkg::STAT_CRED_LSB +: CRED_FLD_W] = CRED_FLD_W'(credits); // zero ext
    status_word[acq_pkg::STAT_MISS_LSB +: MISS_W]     = miss_cnt;
  end

  // readback mux
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      acq_pkg::CFG_CHAN_EN: cfg_rdata[NUM_CHAN-1:0] = chan_en;
      acq_pkg::CFG_MODE: begin
        cfg_rdata[acq_pkg::MODE_ASYNC_BIT]  = async_mode;
        cfg_rdata[acq_pkg::MODE_ACCEPT_BIT] = accept_pulse_triggers;
      end
      acq_pkg::CFG_STATUS:  cfg_rdata = status_word;
      default:              cfg_rdata = '0; // unmapped address
    endcase
  end

endmodule

// ==== common/acq_pkg.sv ====
/* shared types for the acquisition trigger subsystem; the event word is zero padded
   above the trigger type, and the type sits above the 24-bit trigger number */
package acq_pkg;

  // acquisition fsm states, also shown in status bits 1:0
  typedef enum logic [1:0] {
    ACQ_IDLE       = 2'd0, // ready for a ttc trigger, pulse path open
    ACQ_WAIT_DONES = 2'd1, // collecting channel dones
    ACQ_STORE_INFO = 2'd2, // event word pending, needs a credit
    ACQ_READOUT    = 2'd3  // waiting on the command manager
  } acq_state_t;

  // register port addresses
  typedef enum logic [1:0] {
    CFG_CHAN_EN = 2'd0, // channel enable mask
    CFG_MODE    = 2'd1, // async / accept pulse bits
    CFG_STATUS  = 2'd2  // read only
  } cfg_reg_t;

  // event word fields
  localparam int TRIG_TYPE_W = 3;
  localparam int TRIG_NUM_W  = 24;
  localparam int EVT_W       = 32;
  localparam int EVT_PAD_W   = EVT_W - TRIG_TYPE_W - TRIG_NUM_W; // zero bits on top

  // mode register bits
  localparam int MODE_ASYNC_BIT  = 0;
  localparam int MODE_ACCEPT_BIT = 1;

  // status word layout
  localparam int STAT_STATE_LSB = 0;
  localparam int STAT_CRED_LSB  = 4;
  localparam int STAT_CRED_W    = 4;  // bits 7:4
  localparam int STAT_MISS_LSB  = 8;
  localparam int STAT_MISS_W    = 16; // bits 23:8

  // packs type and number into the fifo word
  function automatic logic [EVT_W-1:0] pack_evt(
    input logic [TRIG_TYPE_W-1:0] trig_type,
    input logic [TRIG_NUM_W-1:0]  trig_num
  );
    return {{EVT_PAD_W{1'b0}}, trig_type, trig_num};
  endfunction

endpackage
